// ==== build.f ====
+incdir+testbench
design/cpu_pkg.sv
design/cpu_decode.sv
design/cpu_sequencer.sv
design/cpu_datapath.sv
design/cpu_alu.sv
design/cpu_status.sv
design/cpu_core.sv
testbench/cpu_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench, pass only if the pass line shows up
verilator --binary --timing --assert -f build.f --top-module cpu_tb -o cpu_sim &&
./obj_dir/cpu_sim | grep "TESTBENCH PASSED" ||
{ echo "Simulation did not pass"; exit 1; }

// ==== testbench/cpu_tb_programs.svh ====
`ifndef CPU_TB_PROGRAMS_SVH
`define CPU_TB_PROGRAMS_SVH

typedef struct packed {
	data_t op;  // ALU opcode, immediate form
	data_t a;   // Value for LDA #
	data_t b;   // ALU operand
	logic  ci;  // 1 gives SEC, 0 gives CLC
	data_t br;  // Branch opcode over INX
	logic  rnd; // Operands from the LFSR
} row_t;

localparam int NUM_ROWS = 16;
localparam int ROW_CYCLES = 21;  // LDX, SEC, LDA, op, STA, taken branch, INX, STX
localparam int TAIL_CYCLES = 120; // Both tail sections
localparam addr_t JMP_SELF = 16'h0712; // Last instruction, jumps to itself

// Columns are op, a, b, carry in, branch, random operands
localparam row_t ROWS [NUM_ROWS] = '{
	'{8'h69, 8'h50, 8'h50, 1'b0, 8'h70, 1'b0}, // ADC overflow, BVS
	'{8'h69, 8'h01, 8'h01, 1'b0, 8'h50, 1'b0}, // BVC
	'{8'h69, 8'hff, 8'h01, 1'b0, 8'hb0, 1'b0}, // Carry out, BCS
	'{8'h69, 8'h10, 8'h20, 1'b1, 8'h90, 1'b0}, // Carry in honored, BCC
	'{8'he9, 8'h05, 8'h03, 1'b1, 8'hf0, 1'b0}, // BEQ not taken
	'{8'he9, 8'h80, 8'h01, 1'b1, 8'h70, 1'b0}, // Signed underflow
	'{8'hc9, 8'h40, 8'h40, 1'b0, 8'hf0, 1'b0}, // Equal compare
	'{8'hc9, 8'h10, 8'h20, 1'b0, 8'h30, 1'b0}, // Negative compare, BMI
	'{8'h09, 8'h80, 8'h01, 1'b0, 8'h10, 1'b0}, // BPL not taken
	'{8'h29, 8'hf0, 8'h0f, 1'b1, 8'hd0, 1'b0}, // Zero result, BNE
	'{8'h49, 8'h55, 8'h0f, 1'b0, 8'h30, 1'b0}, // Positive result, BMI not taken
	'{8'he9, 8'h00, 8'h01, 1'b0, 8'h90, 1'b0}, // Borrow, BCC
	'{8'h69, 8'h00, 8'h00, 1'b1, 8'h70, 1'b1},
	'{8'he9, 8'h00, 8'h00, 1'b0, 8'hb0, 1'b1},
	'{8'hc9, 8'h00, 8'h00, 1'b1, 8'hd0, 1'b1},
	'{8'h49, 8'h00, 8'h00, 1'b0, 8'h10, 1'b1}
};

// Tail 1 at the end of the rows: zp/abs loads, transfers, wrap-around
localparam data_t TAIL1 [33] = '{
	8'ha5, 8'h10, 8'haa, 8'he8, 8'h8a, 8'h8d, 8'h00, 8'h03, 8'hac, 8'h34, 8'h12,
	8'h84, 8'h22, 8'ha8, 8'h88, 8'h84, 8'h21, 8'ha2, 8'h00, 8'hca, 8'h86, 8'h23,
	8'ha0, 8'hff, 8'hc8, 8'h84, 8'h24, 8'h98, 8'h85, 8'h25, 8'h4c, 8'hf8, 8'h06
};

// Tail 2 at 06F8: BVC across the page edge, then a DEX/BNE countdown
localparam data_t TAIL2 [29] = '{
	8'ha9, 8'h77, 8'hb8, 8'h50, 8'h04, 8'h8d, 8'h10, 8'h02, 8'hea, 8'h8d,
	8'h02, 8'h02, 8'ha0, 8'h00, 8'ha2, 8'h05, 8'hc8, 8'hca, 8'hd0, 8'hfc,
	8'h8e, 8'h03, 8'h02, 8'h8c, 8'h04, 8'h02, 8'h4c, 8'h12, 8'h07
};

task automatic put_byte(inout addr_t pc, input data_t d);
	mem[pc] = d;
	pc = pc + 16'd1;
endtask

task automatic expect_write(input addr_t a, input data_t d);
	write_t w;
	w.addr = a;
	w.data = d;
	exp_writes.push_back(w);
endtask

task automatic assemble_program();
	addr_t      pc;
	row_t       r;
	data_t      a;
	data_t      b;
	data_t      res;
	data_t      zp_val;
	data_t      abs_val;
	logic       n;
	logic       v;
	logic       z;
	logic       c;
	logic       taken;
	int         us;
	int         sv;
	int         sa;
	int         sb;
	int         i;
	int         k;
	for (k = 0; k < 65536; k++) begin
		mem[k] = data_t'(k[7:0] ^ k[15:8] ^ 8'h3c); // Spreads over both address bytes
	end
	mem[16'hfffc] = 8'h00; // Reset vector to 0400
	mem[16'hfffd] = 8'h04;
	pc = 16'h0400;
	v = 1'b0; // Flags start cleared
	for (i = 0; i < NUM_ROWS; i++) begin
		r = ROWS[i];
		a = r.a;
		b = r.b;
		if (r.rnd) begin
			random_byte(a);
			random_byte(b);
		end
		put_byte(pc, 8'ha2); // LDX #0 first so N/Z come from the op
		put_byte(pc, 8'h00);
		put_byte(pc, r.ci ? 8'h38 : 8'h18);
		put_byte(pc, 8'ha9);
		put_byte(pc, a);
		put_byte(pc, r.op);
		put_byte(pc, b);
		c = r.ci;
		case (r.op)
			8'h09: res = a | b;
			8'h29: res = a & b;
			8'h49: res = a ^ b;
			default: begin // ADC, SBC, CMP as whole-number sums
				sa = int'($signed(a));
				sb = int'($signed(b));
				if (r.op == 8'h69) begin
					us = int'(a) + int'(b) + int'(c);
					sv = sa + sb + int'(c);
				end else if (r.op == 8'he9) begin
					us = int'(a) - int'(b) - int'(!c); // Clear carry borrows one
					sv = sa - sb - int'(!c);
				end else begin
					us = int'(a) - int'(b); // CMP ignores carry in
					sv = sa - sb;
				end
				res = us[7:0];
				c = (r.op == 8'h69) ? (us > 255) : (us >= 0); // Carry out, or no borrow
				if (r.op != 8'hc9) begin
					v = (sv > 127) || (sv < -128); // Outside signed byte range
				end
			end
		endcase
		n = res[7];
		z = (res == 8'h00);
		put_byte(pc, 8'h8d); // STA $0200
		put_byte(pc, 8'h00);
		put_byte(pc, 8'h02);
		expect_write(16'h0200, (r.op == 8'hc9) ? a : res); // CMP keeps A
		case (r.br)
			8'h10: taken = ~n;
			8'h30: taken = n;
			8'h50: taken = ~v;
			8'h70: taken = v;
			8'h90: taken = ~c;
			8'hb0: taken = c;
			8'hd0: taken = ~z;
			default: taken = z;
		endcase
		put_byte(pc, r.br);
		put_byte(pc, 8'h01); // Skip INX
		put_byte(pc, 8'he8);
		put_byte(pc, 8'h8e); // STX $0201
		put_byte(pc, 8'h01);
		put_byte(pc, 8'h02);
		expect_write(16'h0201, taken ? 8'h00 : 8'h01);
	end
	random_byte(zp_val);
	random_byte(abs_val);
	mem[16'h0010] = zp_val;
	mem[16'h1234] = abs_val;
	for (k = 0; k < 33; k++) begin
		put_byte(pc, TAIL1[k]);
	end
	expect_write(16'h0300, zp_val + 8'd1); // TAX, INX, TXA
	expect_write(16'h0022, abs_val);
	expect_write(16'h0021, zp_val); // TAY, DEY
	expect_write(16'h0023, 8'hff); // 00 minus 1
	expect_write(16'h0024, 8'h00); // FF plus 1
	expect_write(16'h0025, 8'h00); // TYA
	pc = 16'h06f8;
	for (k = 0; k < 29; k++) begin
		put_byte(pc, TAIL2[k]);
	end
	expect_write(16'h0202, 8'h77); // Landed past the page edge
	expect_write(16'h0203, 8'h00);
	expect_write(16'h0204, 8'h05); // Loop ran five times
endtask

`endif

// ==== testbench/cpu_tb.sv ====
`timescale 1ns/1ps

module cpu_tb import cpu_pkg::*; ();

	typedef struct packed {
		addr_t addr;
		data_t data;
	} write_t;

	logic        clk = 1'b0;
	logic        reset;
	data_t       data_in;
	addr_t       addr_bus;
	data_t       data_out;
	logic        we;
	data_t       mem [65536];  // Flat 64 KiB memory
	write_t      exp_writes [$]; // Writes in program order
	write_t      w;
	logic [31:0] lfsr;
	int          errors;
	int          cycles;
	int          limit;
	int          i;
	addr_t       vec_addr [3];

	`include "cpu_tb_programs.svh"

	cpu_core u_dut (
		.clk      (clk),
		.reset    (reset),
		.data_in  (data_in),
		.addr_bus (addr_bus),
		.data_out (data_out),
		.we       (we)
	);

	always #20 clk = ~clk;

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		lfsr_step = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1); // Galois taps 32,22,2,1
	endfunction

	task automatic random_byte(output data_t d);
		int j;
		d = 8'h00;
		for (j = 0; j < 8; j++) begin
			d = {d[6:0], lfsr[0]}; // One step per bit
			lfsr = lfsr_step(lfsr);
		end
	endtask

	always @(posedge clk) begin
		data_in <= mem[addr_bus]; // Byte arrives one clock later
		if (we) begin
			mem[addr_bus] <= data_out;
		end
		cycles <= cycles + 1;
	end

	// Bus is settled at the falling edge
	always @(negedge clk) begin
		if (!reset && we) begin
			assert (exp_writes.size() != 0) else begin
				$display("Unexpected write of %h to address %h", data_out, addr_bus);
				errors++;
			end
			if (exp_writes.size() != 0) begin
				w = exp_writes.pop_front();
				assert (addr_bus == w.addr) else begin
					$display("ERROR addr_bus: got %h expected %h", addr_bus, w.addr);
					errors++;
				end
				assert (data_out == w.data) else begin
					$display("ERROR data_out at %h: got %h expected %h", w.addr, data_out, w.data);
					errors++;
				end
			end
		end
	end

	initial begin
		reset = 1'b1;
		data_in = 8'h00;
		errors = 0;
		cycles = 0;
		lfsr = 32'h42aac205;
		vec_addr[0] = 16'hfffc;
		vec_addr[1] = 16'hfffd;
		vec_addr[2] = 16'h0400;
		assemble_program();
		limit = NUM_ROWS * ROW_CYCLES + TAIL_CYCLES + 8 + 3 + 50; // Reset and vector too
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		for (i = 0; i < 3; i++) begin
			@(negedge clk);
			assert (addr_bus == vec_addr[i]) else begin
				$display("ERROR addr_bus: got %h expected %h", addr_bus, vec_addr[i]);
				errors++;
			end
		end
		while (exp_writes.size() != 0 && cycles < limit) begin
			@(negedge clk);
		end
		if (exp_writes.size() != 0) begin
			$display("Timeout after %0d cycles with %0d writes still missing",
				cycles, exp_writes.size());
			errors++;
		end else begin
			repeat (20) begin // CPU must spin on the final JMP
				@(negedge clk);
				assert (addr_bus >= JMP_SELF && addr_bus <= JMP_SELF + 16'd2) else begin
					$display("ERROR addr_bus: got %h expected %h to %h",
						addr_bus, JMP_SELF, JMP_SELF + 16'd2);
					errors++;
				end
			end
		end
		$display("Run complete, %0d errors", errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// ==== design/cpu_core.sv ====
`timescale 1ns/1ps

module cpu_core import cpu_pkg::*; #(
	parameter addr_t RESET_VECTOR = 16'hfffc
) (
	input  logic  clk,
	input  logic  reset,
	input  data_t data_in,
	output addr_t addr_bus,
	output data_t data_out,
	output logic  we
);

	cpu_state_t  state;
	instr_ctrl_t ctrl;
	mode_t       mode;
	data_t       alu_a;
	data_t       alu_b;
	logic        alu_ci;
	alu_op_t     alu_op;
	alu_res_t    alu_res;    // Registered ALU output
	flags_t      flags;
	logic        cond_true;
	logic        branch_back;

	cpu_decode u_decode (
		.clk     (clk),
		.reset   (reset),
		.state   (state),
		.data_in (data_in),
		.ctrl    (ctrl),
		.mode    (mode)
	);

	cpu_sequencer u_sequencer (
		.clk         (clk),
		.reset       (reset),
		.mode        (mode),
		.alu_co      (alu_res.co),
		.cond_true   (cond_true),
		.branch_back (branch_back),
		.state       (state)
	);

	cpu_datapath #(
		.RESET_VECTOR (RESET_VECTOR)
	) u_datapath (
		.clk         (clk),
		.reset       (reset),
		.state       (state),
		.ctrl        (ctrl),
		.data_in     (data_in),
		.alu         (alu_res),
		.flags       (flags),
		.addr_bus    (addr_bus),
		.data_out    (data_out),
		.we          (we),
		.alu_a       (alu_a),
		.alu_b       (alu_b),
		.alu_ci      (alu_ci),
		.alu_op      (alu_op),
		.branch_back (branch_back)
	);

	cpu_alu u_alu (
		.clk   (clk),
		.reset (reset),
		.op    (alu_op),
		.a     (alu_a),
		.b     (alu_b),
		.ci    (alu_ci),
		.res   (alu_res)
	);

	cpu_status u_status (
		.clk       (clk),
		.reset     (reset),
		.state     (state),
		.ctrl      (ctrl),
		.alu       (alu_res),
		.flags     (flags),
		.cond_true (cond_true)
	);

endmodule

// ==== design/cpu_status.sv ====
`timescale 1ns/1ps

module cpu_status import cpu_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  cpu_state_t  state,
	input  instr_ctrl_t ctrl,
	input  alu_res_t    alu,
	output flags_t      flags,
	output logic        cond_true
);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			flags <= '0;
		end else if (state == DECODE) begin
			if (ctrl.load_reg || ctrl.compare) begin
				flags.n <= alu.result[7];
				flags.z <= alu.z;
			end
			if (ctrl.adc_sbc || ctrl.compare) begin
				flags.c <= alu.co; // Carry out, or no borrow
			end else if (ctrl.set_c) begin
				flags.c <= 1'b1;
			end else if (ctrl.clr_c) begin
				flags.c <= 1'b0;
			end
			if (ctrl.adc_sbc) begin
				flags.v <= alu.v;
			end else if (ctrl.clr_v) begin
				flags.v <= 1'b0;
			end
		end
	end

	always_comb begin
		case (ctrl.cond)
			3'b000: cond_true = ~flags.n; // BPL
			3'b001: cond_true = flags.n;  // BMI
			3'b010: cond_true = ~flags.v; // BVC
			3'b011: cond_true = flags.v;  // BVS
			3'b100: cond_true = ~flags.c; // BCC
			3'b101: cond_true = flags.c;  // BCS
			3'b110: cond_true = ~flags.z; // BNE
			default: cond_true = flags.z; // BEQ
		endcase
	end

endmodule

// ==== design/cpu_alu.sv ====
`timescale 1ns/1ps

module cpu_alu import cpu_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  alu_op_t  op,
	input  data_t    a,
	input  data_t    b,
	input  logic     ci,
	output alu_res_t res
);

	data_t      b_in;      // B, inverted for subtract
	logic [8:0] sum;       // Adder with carry out
	data_t      out;       // Selected result
	logic       ovf;       // Signed overflow

	always_comb begin
		b_in = (op == OP_SUB) ? ~b : b;
		sum = {1'b0, a} + {1'b0, b_in} + {8'd0, ci};
		ovf = (a[7] == b_in[7]) && (sum[7] != a[7]); // Same sign in, other sign out
		case (op)
			OP_OR: out = a | b;
			OP_AND: out = a & b;
			OP_EOR: out = a ^ b;
			OP_A: out = a;
			default: out = sum[7:0]; // ADD and SUB
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			res <= '0;
		end else begin
			res.result <= out;
			res.co <= sum[8];
			res.v <= ovf;
			res.z <= (out == 8'h00);
		end
	end

endmodule

// ==== design/cpu_datapath.sv ====
`timescale 1ns/1ps

module cpu_datapath import cpu_pkg::*; #(
	parameter addr_t RESET_VECTOR = 16'hfffc
) (
	input  logic        clk,
	input  logic        reset,
	input  cpu_state_t  state,
	input  instr_ctrl_t ctrl,
	input  data_t       data_in,
	input  alu_res_t    alu,
	input  flags_t      flags,
	output addr_t       addr_bus,
	output data_t       data_out,
	output logic        we,
	output data_t       alu_a,
	output data_t       alu_b,
	output logic        alu_ci,
	output alu_op_t     alu_op,
	output logic        branch_back
);

	addr_t pc;          // Program counter
	addr_t held_addr;   // Address bus of the previous cycle
	data_t regs [3];    // A, X, Y
	data_t src_val;     // Selected source register
	logic  pc_load;     // PC takes the address bus
	logic  pc_inc;      // PC steps past the byte addressed

	assign src_val = regs[ctrl.src_reg];
	assign data_out = src_val; // Store data
	assign we = ctrl.store && (state == ZP0 || state == ABS1);

	always_comb begin
		case (state)
			VEC0: addr_bus = RESET_VECTOR;
			VEC1: addr_bus = RESET_VECTOR + 16'd1;
			VEC2, JMP1, ABS1: addr_bus = {data_in, alu.result}; // High byte live, low from ALU
			BRA1: addr_bus = {held_addr[15:8], alu.result};
			BRA2: addr_bus = {alu.result, held_addr[7:0]}; // Fixed up high byte
			ZP0: addr_bus = {ZERO_PAGE, data_in};
			REG: addr_bus = held_addr; // Re-read the next opcode
			default: addr_bus = pc;
		endcase
	end

	always_comb begin
		pc_load = 1'b0;
		pc_inc = 1'b0;
		case (state)
			VEC2, JMP1: begin
				pc_load = 1'b1;
				pc_inc = 1'b1;
			end
			BRA1: begin
				pc_load = 1'b1;
				pc_inc = ~(alu.co ^ branch_back); // Skip the step if a fixup follows
			end
			BRA2: begin
				pc_load = 1'b1;
				pc_inc = 1'b1;
			end
			DECODE, FETCH, ABS0, BRA0: pc_inc = 1'b1;
			default: pc_inc = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		pc <= (pc_load ? addr_bus : pc) + {15'd0, pc_inc};
		held_addr <= addr_bus;
		if (state == DECODE && ctrl.load_reg) begin
			regs[ctrl.dst_reg] <= alu.result; // Overlaps the next opcode read
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			branch_back <= 1'b0;
		end else if (state == BRA0) begin
			branch_back <= data_in[7]; // Offset sign
		end
	end

	always_comb begin
		alu_a = 8'h00;
		alu_b = data_in;
		alu_ci = 1'b0;
		alu_op = OP_ADD; // Default passes data_in through
		case (state)
			FETCH: begin
				alu_a = ctrl.load_only ? 8'h00 : src_val;
				alu_ci = ctrl.compare ? 1'b1 : (ctrl.load_only ? 1'b0 : flags.c);
				alu_op = ctrl.alu_op;
			end
			REG: begin
				alu_a = src_val;
				alu_b = 8'h00;
				alu_ci = ctrl.inc_dec; // Plus 1, or SUB of 0 gives minus 1
				alu_op = ctrl.alu_op;
			end
			BRA0: begin
				alu_a = data_in; // Offset
				alu_b = pc[7:0];
			end
			BRA1: begin
				alu_a = held_addr[15:8];
				alu_b = 8'h00;
				alu_ci = alu.co;
				alu_op = branch_back ? OP_SUB : OP_ADD; // Borrow or carry into PCH
			end
			default: alu_op = OP_ADD;
		endcase
	end

endmodule

// ==== design/cpu_sequencer.sv ====
`timescale 1ns/1ps

module cpu_sequencer import cpu_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  mode_t      mode,
	input  logic       alu_co,
	input  logic       cond_true,
	input  logic       branch_back,
	output cpu_state_t state
);

	logic page_cross; // Branch target left the current page

	// Forward with carry, or backward without carry, lands on another page
	assign page_cross = alu_co ^ branch_back;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= VEC0;
		end else begin
			case (state)
				VEC0: state <= VEC1;
				VEC1: state <= VEC2;
				VEC2: state <= DECODE; // First opcode being read
				DECODE: begin
					case (mode)
						M_IMM: state <= FETCH;
						M_ZP: state <= ZP0;
						M_ABS: state <= ABS0;
						M_BRA: state <= BRA0;
						M_JMP: state <= JMP0;
						default: state <= REG; // Implied, NOP
					endcase
				end
				ZP0: state <= FETCH;
				ABS0: state <= ABS1;
				ABS1: state <= FETCH;
				FETCH: state <= DECODE;
				REG: state <= DECODE;
				BRA0: state <= cond_true ? BRA1 : DECODE; // Not taken, opcode already out
				BRA1: state <= page_cross ? BRA2 : DECODE;
				BRA2: state <= DECODE;
				JMP0: state <= JMP1;
				JMP1: state <= DECODE;
				default: state <= VEC0;
			endcase
		end
	end

endmodule

// ==== design/cpu_decode.sv ====
`timescale 1ns/1ps

module cpu_decode import cpu_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  cpu_state_t  state,
	input  data_t       data_in,
	output instr_ctrl_t ctrl,
	output mode_t       mode
);

	instr_ctrl_t next_ctrl; // Decode of the opcode now on data_in
	reg_sel_t    xy_sel;    // Index register of the LDX/LDY/STX/STY group

	always_comb begin
		next_ctrl = CTRL_NOP;
		next_ctrl.cond = data_in[7:5]; // Only looked at by branches
		mode = M_IMPL;
		xy_sel = data_in[1] ? SEL_X : SEL_Y; // Bit 1 set for X forms
		casez (data_in)
			8'b???0_0101, 8'b???0_1001, 8'b???0_1101: begin // ALU column, zp/imm/abs
				mode = data_in[3] ? (data_in[2] ? M_ABS : M_IMM) : M_ZP;
				case (data_in[7:5])
					3'b011: begin // ADC
						next_ctrl.load_reg = 1'b1;
						next_ctrl.adc_sbc = 1'b1;
					end
					3'b100: begin // STA
						next_ctrl.store = 1'b1;
					end
					3'b101: begin // LDA
						next_ctrl.load_reg = 1'b1;
						next_ctrl.load_only = 1'b1;
					end
					3'b110: begin // CMP, A left alone
						next_ctrl.alu_op = OP_SUB;
						next_ctrl.compare = 1'b1;
					end
					3'b111: begin // SBC
						next_ctrl.alu_op = OP_SUB;
						next_ctrl.load_reg = 1'b1;
						next_ctrl.adc_sbc = 1'b1;
					end
					default: begin // ORA, AND, EOR
						next_ctrl.alu_op = alu_op_t'({2'b11, data_in[6:5]});
						next_ctrl.load_reg = 1'b1;
					end
				endcase
			end
			8'b1010_00?0, 8'b10?0_01?0, 8'b10?0_11?0: begin // LDX/LDY/STX/STY
				mode = data_in[3] ? M_ABS : (data_in[2] ? M_ZP : M_IMM);
				next_ctrl.src_reg = xy_sel;
				next_ctrl.dst_reg = xy_sel;
				next_ctrl.store = ~data_in[5]; // 8x row stores
				next_ctrl.load_reg = data_in[5]; // Ax row loads
				next_ctrl.load_only = data_in[5];
			end
			8'b???1_0000: mode = M_BRA; // All eight branches
			8'h4c: mode = M_JMP; // JMP abs
			8'h18: next_ctrl.clr_c = 1'b1; // CLC
			8'h38: next_ctrl.set_c = 1'b1; // SEC
			8'hb8: next_ctrl.clr_v = 1'b1; // CLV
			8'haa: begin // TAX
				next_ctrl.dst_reg = SEL_X;
				next_ctrl.load_reg = 1'b1;
			end
			8'ha8: begin // TAY
				next_ctrl.dst_reg = SEL_Y;
				next_ctrl.load_reg = 1'b1;
			end
			8'h8a: begin // TXA
				next_ctrl.src_reg = SEL_X;
				next_ctrl.load_reg = 1'b1;
			end
			8'h98: begin // TYA
				next_ctrl.src_reg = SEL_Y;
				next_ctrl.load_reg = 1'b1;
			end
			8'he8, 8'hc8: begin // INX, INY
				next_ctrl.src_reg = data_in[5] ? SEL_X : SEL_Y;
				next_ctrl.dst_reg = data_in[5] ? SEL_X : SEL_Y;
				next_ctrl.inc_dec = 1'b1;
				next_ctrl.load_reg = 1'b1;
			end
			8'hca, 8'h88: begin // DEX, DEY: add FF
				next_ctrl.src_reg = data_in[6] ? SEL_X : SEL_Y;
				next_ctrl.dst_reg = data_in[6] ? SEL_X : SEL_Y;
				next_ctrl.alu_op = OP_SUB;
				next_ctrl.load_reg = 1'b1;
			end
			default: mode = M_IMPL; // NOP and unknown opcodes
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			ctrl <= CTRL_NOP;
		end else if (state == DECODE) begin
			ctrl <= next_ctrl; // Held until the next DECODE
		end
	end

endmodule

// ==== design/cpu_pkg.sv ====
package cpu_pkg;

	typedef logic [7:0]  data_t; // Data byte
	typedef logic [15:0] addr_t; // Address bus word
	typedef logic [2:0]  cond_t; // Branch condition, opcode bits 7:5

	typedef enum logic [3:0] {
		OP_OR  = 4'b1100,
		OP_AND = 4'b1101,
		OP_EOR = 4'b1110,
		OP_ADD = 4'b0011,
		OP_SUB = 4'b0111, // A plus inverted B plus carry
		OP_A   = 4'b1111  // Pass A
	} alu_op_t;

	typedef enum logic [1:0] {
		SEL_A = 2'd0,
		SEL_X = 2'd1,
		SEL_Y = 2'd2
	} reg_sel_t;

	typedef enum logic [4:0] {
		VEC0,   // Read vector low byte
		VEC1,   // Read vector high byte, low byte into ALU
		VEC2,   // Jump to vector target
		DECODE, // Opcode on data_in, previous result written
		FETCH,  // Operand on data_in, ALU op, next opcode read
		REG,    // Register to register op
		ZP0,    // Zero page address on data_in
		ABS0,   // Absolute low byte
		ABS1,   // Absolute high byte
		BRA0,   // Offset plus PCL
		BRA1,   // High byte fixup in ALU
		BRA2,   // Page crossed
		JMP0,   // Target low byte
		JMP1    // Target high byte
	} cpu_state_t;

	typedef enum logic [2:0] {
		M_IMM,
		M_ZP,
		M_ABS,
		M_IMPL,
		M_BRA,
		M_JMP
	} mode_t;

	typedef struct packed {
		alu_op_t  alu_op;
		reg_sel_t src_reg;
		reg_sel_t dst_reg;
		logic     load_reg;  // Result goes to dst_reg
		logic     load_only; // LDA/LDX/LDY
		logic     store;     // STA/STX/STY
		logic     compare;   // CMP
		logic     adc_sbc;   // ADC/SBC
		logic     inc_dec;   // Carry in 1 for INX/INY
		logic     set_c;
		logic     clr_c;
		logic     clr_v;
		cond_t    cond;
	} instr_ctrl_t;

	typedef struct packed {
		logic n;
		logic v;
		logic z;
		logic c;
	} flags_t;

	typedef struct packed {
		data_t result;
		logic  co;
		logic  v;
		logic  z;
	} alu_res_t;

	localparam data_t ZERO_PAGE = 8'h00; // High byte of zero page accesses

	localparam instr_ctrl_t CTRL_NOP = '{
		alu_op:  OP_ADD,
		src_reg: SEL_A,
		dst_reg: SEL_A,
		cond:    3'b000,
		default: 1'b0
	};

endpackage
